//--- src/ctrl_pkg.sv
/*
 * controller package: architectural widths, fetch address selectors,
 * synchronous exception codes and the trap-cause word
 */
`default_nettype none

package ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths fixed by the ISA
  //////////////////////////////////////////////////////////////////////

  // instruction, fault address and mtval words
  parameter int unsigned XLEN     = 32;
  // compressed instruction half word
  parameter int unsigned COMP_W   = 16;
  // interrupt identifier from the interrupt controller
  parameter int unsigned IRQ_ID_W = 5;
  // mcause as seen by the controller
  parameter int unsigned CAUSE_W  = 6;

  //////////////////////////////////////////////////////////////////////
  // selectors toward the IF stage
  //////////////////////////////////////////////////////////////////////

  // fetch address source
  typedef enum logic [1:0] {
    PC_BOOT = 2'b00,
    PC_JUMP = 2'b01,
    PC_EXC  = 2'b10,
    PC_ERET = 2'b11
  } pc_sel_e;

  // exception vector, synchronous trap or interrupt
  typedef enum logic [0:0] {
    EXC_PC_EXC = 1'b0,
    EXC_PC_IRQ = 1'b1
  } exc_pc_sel_e;

  //////////////////////////////////////////////////////////////////////
  // trap cause
  //////////////////////////////////////////////////////////////////////

  // synchronous exception codes, top bit always clear
  typedef enum logic [CAUSE_W-1:0] {
    EXC_CAUSE_ILLEGAL_INSN       = 6'd2,
    EXC_CAUSE_BREAKPOINT         = 6'd3,
    EXC_CAUSE_LOAD_ACCESS_FAULT  = 6'd5,
    EXC_CAUSE_STORE_ACCESS_FAULT = 6'd7,
    EXC_CAUSE_ECALL_MMODE        = 6'd11
  } exc_code_e;

  // interrupt view: flag on top of the interrupt id
  typedef struct packed {
    logic                irq;
    logic [IRQ_ID_W-1:0] id;
  } irq_cause_t;

  // one cause word, decoded as exception code or as interrupt
  typedef union packed {
    exc_code_e  code;
    irq_cause_t intr;
  } exc_cause_u;

endpackage

`default_nettype wire

//--- src/trap_if.sv
/* trap interface between the controller FSM and the trap cause selector */
`timescale 1ns/1ps
`default_nettype none

interface trap_if
  import ctrl_pkg::*;
();

  // load/store faults latched in the decode cycle that enters flush
  logic            load_err_q;
  logic            store_err_q;

  // redirect for the instruction held in ID
  logic            trap_pc_set;
  pc_sel_e         trap_pc_sel;
  exc_pc_sel_e     trap_exc_pc_sel;
  exc_cause_u      trap_cause;
  // save PC of ID and the cause
  logic            trap_csr_save;
  logic            trap_restore_mret;
  logic [XLEN-1:0] trap_mtval;

  // controller side, owns the fault latches
  modport fsm (
    output load_err_q,
    output store_err_q,
    input  trap_pc_set,
    input  trap_pc_sel,
    input  trap_exc_pc_sel,
    input  trap_cause,
    input  trap_csr_save,
    input  trap_restore_mret,
    input  trap_mtval
  );

  // cause selector side, computes the redirect every cycle
  modport sel (
    input  load_err_q,
    input  store_err_q,
    output trap_pc_set,
    output trap_pc_sel,
    output trap_exc_pc_sel,
    output trap_cause,
    output trap_csr_save,
    output trap_restore_mret,
    output trap_mtval
  );

endinterface

`default_nettype wire

//--- src/trap_cause_sel.sv
/*
 * trap cause selector: prioritized decode of the flushed instruction
 * into redirect, exception code, CSR strobes and mtval
 */
`timescale 1ns/1ps
`default_nettype none

module trap_cause_sel
  import ctrl_pkg::*;
(
  // decoder flags for the instruction in ID
  input  logic              ecall_insn_i,
  input  logic              illegal_insn_i,
  input  logic              mret_insn_i,
  input  logic              ebrk_insn_i,

  // IF/ID register, source of mtval on illegal instructions
  input  logic [XLEN-1:0]   instr_i,
  input  logic [COMP_W-1:0] instr_compressed_i,
  input  logic              instr_is_compressed_i,

  // last LSU address, source of mtval on access faults
  input  logic [XLEN-1:0]   lsu_addr_last_i,

  trap_if.sel               trap_io
);

  logic [XLEN-1:0] illegal_tval;

  // mtval holds the offending encoding as fetched
  // compressed instructions are zero-extended
  assign illegal_tval = instr_is_compressed_i ?
                        {{(XLEN-COMP_W){1'b0}}, instr_compressed_i} : instr_i;

  //////////////////////////////////////////////////////////////////////
  // priority: ecall, illegal, mret, ebreak, load fault, store fault
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // defaults describe a synchronous exception
    trap_io.trap_pc_set       = 1'b1;
    trap_io.trap_pc_sel       = PC_EXC;
    trap_io.trap_exc_pc_sel   = EXC_PC_EXC;
    trap_io.trap_cause        = '0;
    trap_io.trap_csr_save     = 1'b1;
    trap_io.trap_restore_mret = 1'b0;
    trap_io.trap_mtval        = '0;

    if (ecall_insn_i) begin
      trap_io.trap_cause.code = EXC_CAUSE_ECALL_MMODE;
    end else if (illegal_insn_i) begin
      trap_io.trap_cause.code = EXC_CAUSE_ILLEGAL_INSN;
      trap_io.trap_mtval      = illegal_tval;
    end else if (mret_insn_i) begin
      // return from trap, restore mstatus from the saved copy
      // nothing is saved, mepc gives the target
      trap_io.trap_pc_sel       = PC_ERET;
      trap_io.trap_csr_save     = 1'b0;
      trap_io.trap_restore_mret = 1'b1;
    end else if (ebrk_insn_i) begin
      // without debug support ebreak is a plain breakpoint
      trap_io.trap_cause.code = EXC_CAUSE_BREAKPOINT;
    end else if (trap_io.load_err_q) begin
      trap_io.trap_cause.code = EXC_CAUSE_LOAD_ACCESS_FAULT;
      trap_io.trap_mtval      = lsu_addr_last_i;
    end else if (trap_io.store_err_q) begin
      trap_io.trap_cause.code = EXC_CAUSE_STORE_ACCESS_FAULT;
      trap_io.trap_mtval      = lsu_addr_last_i;
    end else begin
      // csr status or plain pipe flush, no redirect
      trap_io.trap_pc_set   = 1'b0;
      trap_io.trap_csr_save = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- src/ctrl_fsm.sv
/*
 * controller FSM: boot, decode, flush and interrupt entry, sleep,
 * load/store fault latches and stall control toward IF/ID
 */
`timescale 1ns/1ps
`default_nettype none

module ctrl_fsm
  import ctrl_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,

  input  logic                fetch_enable_i,

  // decoder flags
  input  logic                illegal_insn_i,
  input  logic                ecall_insn_i,
  input  logic                mret_insn_i,
  input  logic                ebrk_insn_i,
  input  logic                csr_status_i,
  input  logic                pipe_flush_i,

  // IF/ID register and LSU faults
  input  logic                instr_valid_i,
  input  logic                load_err_i,
  input  logic                store_err_i,

  // taken jump or branch in ID
  input  logic                branch_set_i,
  input  logic                jump_set_i,

  // interrupts
  input  logic                irq_i,
  input  logic                irq_req_ctrl_i,
  input  logic [IRQ_ID_W-1:0] irq_id_ctrl_i,
  input  logic                m_ie_i,

  // stall sources
  input  logic                stall_lsu_i,
  input  logic                stall_multdiv_i,
  input  logic                stall_jump_i,
  input  logic                stall_branch_i,

  // prefetcher and IF stage
  output logic                instr_req_o,
  output logic                pc_set_o,
  output pc_sel_e             pc_mux_o,
  output exc_pc_sel_e         exc_pc_mux_o,

  // trap and interrupt entry
  output exc_cause_u          exc_cause_o,
  output logic                exc_ack_o,
  output logic                irq_ack_o,
  output logic [IRQ_ID_W-1:0] irq_id_o,

  // CSR strobes
  output logic                csr_save_if_o,
  output logic                csr_save_id_o,
  output logic                csr_save_cause_o,
  output logic                csr_restore_mret_id_o,
  output logic [XLEN-1:0]     csr_mtval_o,

  // IF/ID control
  output logic                halt_if_o,
  output logic                id_ready_o,
  output logic                id_valid_o,
  output logic                instr_valid_clear_o,
  output logic                deassert_we_o,
  output logic                is_decoding_o,

  trap_if.fsm                 trap_io
);

  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_fsm_e;

  ctrl_fsm_e ctrl_fsm_cs;
  ctrl_fsm_e ctrl_fsm_ns;

  logic irq_take;
  logic flush_req;
  logic halt_id;
  logic load_err_n;
  logic store_err_n;

  // pending interrupt that machine mode accepts
  assign irq_take  = irq_req_ctrl_i & m_ie_i;

  // anything in ID that needs the pipe flushed
  assign flush_req = illegal_insn_i | ecall_insn_i | mret_insn_i | ebrk_insn_i |
                     csr_status_i | pipe_flush_i | load_err_i | store_err_i;

  assign irq_id_o  = irq_id_ctrl_i;

  //////////////////////////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_fsm_ns           = ctrl_fsm_cs;

    instr_req_o           = 1'b1;
    pc_set_o              = 1'b0;
    pc_mux_o              = PC_BOOT;
    exc_pc_mux_o          = EXC_PC_IRQ;
    exc_cause_o           = '0;
    exc_ack_o             = 1'b0;
    irq_ack_o             = 1'b0;

    csr_save_if_o         = 1'b0;
    csr_save_id_o         = 1'b0;
    csr_save_cause_o      = 1'b0;
    csr_restore_mret_id_o = 1'b0;
    csr_mtval_o           = '0;

    halt_id               = 1'b0;
    is_decoding_o         = 1'b0;
    load_err_n            = 1'b0;
    store_err_n           = 1'b0;

    unique case (ctrl_fsm_cs)
      // hold the boot address until fetch is enabled
      RESET: begin
        instr_req_o = 1'b0;
        pc_set_o    = 1'b1;
        if (fetch_enable_i) begin
          ctrl_fsm_ns = BOOT_SET;
        end
      end

      // load boot address into the fetch PC
      BOOT_SET: begin
        pc_set_o    = 1'b1;
        ctrl_fsm_ns = FIRST_FETCH;
      end

      // one idle cycle before sleep, fetch stays off
      WAIT_SLEEP: begin
        instr_req_o = 1'b0;
        halt_id     = 1'b1;
        ctrl_fsm_ns = SLEEP;
      end

      // only irq_i wakes the core, taken or not
      SLEEP: begin
        instr_req_o = 1'b0;
        halt_id     = 1'b1;
        if (irq_i) begin
          ctrl_fsm_ns = FIRST_FETCH;
        end
      end

      // wait for the first instruction to reach ID
      FIRST_FETCH: begin
        if (id_ready_o) begin
          ctrl_fsm_ns = DECODE;
        end
        // pipe is empty here, interrupt can go in directly
        if (irq_take) begin
          halt_id     = 1'b1;
          ctrl_fsm_ns = IRQ_TAKEN;
        end
      end

      DECODE: begin
        if (irq_take) begin
          // interrupt wins over the instruction in ID
          halt_id     = 1'b1;
          ctrl_fsm_ns = IRQ_TAKEN;
        end else if (instr_valid_i) begin
          is_decoding_o = 1'b1;
          if (branch_set_i || jump_set_i) begin
            // redirect in the same cycle
            pc_set_o = 1'b1;
            pc_mux_o = PC_JUMP;
          end else if (flush_req) begin
            // keep the instruction in ID for the flush cycle
            halt_id     = 1'b1;
            load_err_n  = load_err_i;
            store_err_n = store_err_i;
            ctrl_fsm_ns = FLUSH;
          end
        end
      end

      // forward what the cause selector computed for ID
      FLUSH: begin
        halt_id               = 1'b1;
        pc_set_o              = trap_io.trap_pc_set;
        pc_mux_o              = trap_io.trap_pc_sel;
        exc_pc_mux_o          = trap_io.trap_exc_pc_sel;
        exc_cause_o           = trap_io.trap_cause;
        csr_save_id_o         = trap_io.trap_csr_save;
        csr_save_cause_o      = trap_io.trap_csr_save;
        csr_restore_mret_id_o = trap_io.trap_restore_mret;
        csr_mtval_o           = trap_io.trap_mtval;
        // wfi reaches here as a pipe flush
        ctrl_fsm_ns           = pipe_flush_i ? WAIT_SLEEP : DECODE;
      end

      // jump to the interrupt vector, save PC of IF
      IRQ_TAKEN: begin
        pc_set_o              = 1'b1;
        pc_mux_o              = PC_EXC;
        exc_pc_mux_o          = EXC_PC_IRQ;
        exc_cause_o.intr.irq  = 1'b1;
        exc_cause_o.intr.id   = irq_id_ctrl_i;
        csr_save_if_o         = 1'b1;
        csr_save_cause_o      = 1'b1;
        irq_ack_o             = 1'b1;
        exc_ack_o             = 1'b1;
        ctrl_fsm_ns           = DECODE;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // stall control
  //////////////////////////////////////////////////////////////////////

  // IF stage halts together with ID
  assign halt_if_o           = halt_id;

  // any stall source holds the instruction in ID
  assign id_ready_o          = ~(stall_lsu_i | stall_multdiv_i | stall_jump_i |
                                 stall_branch_i);

  // drop the IF/ID entry once done or while halted
  assign instr_valid_clear_o = id_ready_o | halt_id;
  assign id_valid_o          = id_ready_o & ~halt_id;

  // no register writes outside decode or for illegal encodings
  assign deassert_we_o       = ~is_decoding_o | illegal_insn_i;

  // state and fault latches
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_fsm_cs         <= RESET;
      trap_io.load_err_q  <= 1'b0;
      trap_io.store_err_q <= 1'b0;
    end else begin
      ctrl_fsm_cs         <= ctrl_fsm_ns;
      trap_io.load_err_q  <= load_err_n;
      trap_io.store_err_q <= store_err_n;
    end
  end

endmodule

`default_nettype wire

//--- src/ctrl_top.sv
/* controller top level: FSM, trap cause selector and their interface */
`timescale 1ns/1ps
`default_nettype none

module ctrl_top
  import ctrl_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                fetch_enable_i,

  // decoder flags
  input  logic                illegal_insn_i,
  input  logic                ecall_insn_i,
  input  logic                mret_insn_i,
  input  logic                ebrk_insn_i,
  input  logic                csr_status_i,
  input  logic                pipe_flush_i,

  // IF/ID register
  input  logic                instr_valid_i,
  input  logic [XLEN-1:0]     instr_i,
  input  logic [COMP_W-1:0]   instr_compressed_i,
  input  logic                instr_is_compressed_i,

  // LSU
  input  logic [XLEN-1:0]     lsu_addr_last_i,
  input  logic                load_err_i,
  input  logic                store_err_i,

  // jumps and branches
  input  logic                branch_set_i,
  input  logic                jump_set_i,

  // interrupts
  input  logic                irq_i,
  input  logic                irq_req_ctrl_i,
  input  logic [IRQ_ID_W-1:0] irq_id_ctrl_i,
  input  logic                m_ie_i,

  // stalls
  input  logic                stall_lsu_i,
  input  logic                stall_multdiv_i,
  input  logic                stall_jump_i,
  input  logic                stall_branch_i,

  // prefetcher and IF stage
  output logic                instr_req_o,
  output logic                pc_set_o,
  output pc_sel_e             pc_mux_o,
  output exc_pc_sel_e         exc_pc_mux_o,

  // trap and interrupt entry
  output logic [CAUSE_W-1:0]  exc_cause_o,
  output logic                exc_ack_o,
  output logic                irq_ack_o,
  output logic [IRQ_ID_W-1:0] irq_id_o,

  // CSR strobes
  output logic                csr_save_if_o,
  output logic                csr_save_id_o,
  output logic                csr_save_cause_o,
  output logic                csr_restore_mret_id_o,
  output logic [XLEN-1:0]     csr_mtval_o,

  // IF/ID control
  output logic                halt_if_o,
  output logic                id_ready_o,
  output logic                id_valid_o,
  output logic                instr_valid_clear_o,
  output logic                deassert_we_o,
  output logic                is_decoding_o
);

  exc_cause_u fsm_cause;

  trap_if u_trap_if ();

  ctrl_fsm u_fsm (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .fetch_enable_i        (fetch_enable_i),
    .illegal_insn_i        (illegal_insn_i),
    .ecall_insn_i          (ecall_insn_i),
    .mret_insn_i           (mret_insn_i),
    .ebrk_insn_i           (ebrk_insn_i),
    .csr_status_i          (csr_status_i),
    .pipe_flush_i          (pipe_flush_i),
    .instr_valid_i         (instr_valid_i),
    .load_err_i            (load_err_i),
    .store_err_i           (store_err_i),
    .branch_set_i          (branch_set_i),
    .jump_set_i            (jump_set_i),
    .irq_i                 (irq_i),
    .irq_req_ctrl_i        (irq_req_ctrl_i),
    .irq_id_ctrl_i         (irq_id_ctrl_i),
    .m_ie_i                (m_ie_i),
    .stall_lsu_i           (stall_lsu_i),
    .stall_multdiv_i       (stall_multdiv_i),
    .stall_jump_i          (stall_jump_i),
    .stall_branch_i        (stall_branch_i),
    .instr_req_o           (instr_req_o),
    .pc_set_o              (pc_set_o),
    .pc_mux_o              (pc_mux_o),
    .exc_pc_mux_o          (exc_pc_mux_o),
    .exc_cause_o           (fsm_cause),
    .exc_ack_o             (exc_ack_o),
    .irq_ack_o             (irq_ack_o),
    .irq_id_o              (irq_id_o),
    .csr_save_if_o         (csr_save_if_o),
    .csr_save_id_o         (csr_save_id_o),
    .csr_save_cause_o      (csr_save_cause_o),
    .csr_restore_mret_id_o (csr_restore_mret_id_o),
    .csr_mtval_o           (csr_mtval_o),
    .halt_if_o             (halt_if_o),
    .id_ready_o            (id_ready_o),
    .id_valid_o            (id_valid_o),
    .instr_valid_clear_o   (instr_valid_clear_o),
    .deassert_we_o         (deassert_we_o),
    .is_decoding_o         (is_decoding_o),
    .trap_io               (u_trap_if.fsm)
  );

  trap_cause_sel u_trap (
    .ecall_insn_i          (ecall_insn_i),
    .illegal_insn_i        (illegal_insn_i),
    .mret_insn_i           (mret_insn_i),
    .ebrk_insn_i           (ebrk_insn_i),
    .instr_i               (instr_i),
    .instr_compressed_i    (instr_compressed_i),
    .instr_is_compressed_i (instr_is_compressed_i),
    .lsu_addr_last_i       (lsu_addr_last_i),
    .trap_io               (u_trap_if.sel)
  );

  // mcause leaves the controller as a plain bus
  assign exc_cause_o = fsm_cause;

endmodule

`default_nettype wire

//--- verification/tb_ctrl_vectors.svh
/*
 * controller testbench table: scenario kinds, entry type and the entries
 */
`ifndef TB_CTRL_VECTORS_SVH
`define TB_CTRL_VECTORS_SVH

// what an entry raises while the controller is in decode
typedef enum logic [3:0] {
  VK_NONE,
  VK_ILLEGAL,
  VK_ECALL,
  VK_EBREAK,
  VK_MRET,
  VK_CSR,
  VK_LOAD,
  VK_STORE,
  VK_IRQ,
  VK_IRQ_MASKED
} vec_kind_e;

// stall bits: {branch, jump, multdiv, lsu}
// strobes, msb first: pc_set, irq vector, save_if, save_id, save_cause,
// restore_mret, irq/exc ack, halt_if
typedef struct packed {
  vec_kind_e           kind;
  logic                compressed;
  logic [XLEN-1:0]     instr;
  logic [XLEN-1:0]     addr;
  logic [IRQ_ID_W-1:0] irq_id;
  logic [3:0]          stall;
  logic [CAUSE_W-1:0]  exp_cause;
  pc_sel_e             exp_pc_mux;
  logic [XLEN-1:0]     exp_mtval;
  logic [7:0]          exp_strb;
} vec_t;

localparam int NUM_VECS = 14;

vec_t vectors [NUM_VECS] = '{
  // kind      comp  instr         addr          id     stall cause  pc_mux   mtval         strb
  '{VK_ILLEGAL, 1'b0, 32'h0000107f, 32'h0,        5'd0,  4'h0, 6'd2,  PC_EXC,  32'h0000107f, 8'h99},
  // compressed half only, upper bits of the word must not reach mtval
  '{VK_ILLEGAL, 1'b1, 32'hffff8b3e, 32'h0,        5'd0,  4'h0, 6'd2,  PC_EXC,  32'h00008b3e, 8'h99},
  '{VK_ECALL,   1'b0, 32'h00000073, 32'h0,        5'd0,  4'h0, 6'd11, PC_EXC,  32'h0,        8'h99},
  '{VK_EBREAK,  1'b0, 32'h00100073, 32'h0,        5'd0,  4'h0, 6'd3,  PC_EXC,  32'h0,        8'h99},
  '{VK_MRET,    1'b0, 32'h30200073, 32'h0,        5'd0,  4'h0, 6'd0,  PC_ERET, 32'h0,        8'h85},
  // csr status flushes without a redirect
  '{VK_CSR,     1'b0, 32'h30029073, 32'h0,        5'd0,  4'h0, 6'd0,  PC_BOOT, 32'h0,        8'h01},
  '{VK_LOAD,    1'b0, 32'h00012083, 32'h80001ffc, 5'd0,  4'h0, 6'd5,  PC_EXC,  32'h80001ffc, 8'h99},
  '{VK_STORE,   1'b0, 32'h00112023, 32'h00002a40, 5'd0,  4'h0, 6'd7,  PC_EXC,  32'h00002a40, 8'h99},
  // interrupt flag over id 17
  '{VK_IRQ,     1'b0, 32'h00000013, 32'h0,        5'd17, 4'h0, 6'h31, PC_EXC,  32'h0,        8'hea},
  '{VK_IRQ_MASKED, 1'b0, 32'h00000013, 32'h0,     5'd3,  4'h0, 6'd0,  PC_BOOT, 32'h0,        8'h00},
  '{VK_NONE,    1'b0, 32'h00000013, 32'h0,        5'd0,  4'h1, 6'd0,  PC_BOOT, 32'h0,        8'h00},
  '{VK_NONE,    1'b0, 32'h00000013, 32'h0,        5'd0,  4'h2, 6'd0,  PC_BOOT, 32'h0,        8'h00},
  '{VK_NONE,    1'b0, 32'h00000013, 32'h0,        5'd0,  4'h4, 6'd0,  PC_BOOT, 32'h0,        8'h00},
  '{VK_NONE,    1'b0, 32'h00000013, 32'h0,        5'd0,  4'h8, 6'd0,  PC_BOOT, 32'h0,        8'h00}
};

`endif

//--- verification/tb_ctrl_top.sv
/* controller testbench: clock, reset, boot, table loop, sleep, watchdog */
`timescale 1ns/1ps
`default_nettype none

module tb_ctrl_top
  import ctrl_pkg::*;
();

  localparam int CLK_PERIOD   = 8;
  localparam int BOOT_CYCLES  = 10;
  localparam int SLEEP_CYCLES = 20;
  localparam int WAKE_LIMIT   = 4;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic fetch_enable_i;
  logic illegal_insn_i, ecall_insn_i, mret_insn_i, ebrk_insn_i, csr_status_i, pipe_flush_i;
  logic instr_valid_i, instr_is_compressed_i;
  logic [XLEN-1:0] instr_i;
  logic [COMP_W-1:0] instr_compressed_i;
  logic [XLEN-1:0] lsu_addr_last_i;
  logic load_err_i, store_err_i, branch_set_i, jump_set_i;
  logic irq_i, irq_req_ctrl_i, m_ie_i;
  logic [IRQ_ID_W-1:0] irq_id_ctrl_i;
  logic stall_lsu_i, stall_multdiv_i, stall_jump_i, stall_branch_i;

  logic instr_req_o, pc_set_o;
  pc_sel_e pc_mux_o;
  exc_pc_sel_e exc_pc_mux_o;
  logic [CAUSE_W-1:0] exc_cause_o;
  logic exc_ack_o, irq_ack_o;
  logic [IRQ_ID_W-1:0] irq_id_o;
  logic csr_save_if_o, csr_save_id_o, csr_save_cause_o, csr_restore_mret_id_o;
  logic [XLEN-1:0] csr_mtval_o;
  logic halt_if_o, id_ready_o, id_valid_o, instr_valid_clear_o, deassert_we_o;
  logic is_decoding_o;

  integer seed   = 32'h8dbe;
  int     errors = 0;
  int     checks = 0;
  string  phase  = "reset";

  `include "tb_ctrl_vectors.svh"

  // ten cycles per entry plus boot and the sleep sequence
  localparam int TIMEOUT_CYCLES = NUM_VECS * 10 + BOOT_CYCLES + SLEEP_CYCLES;

  ctrl_top u_dut (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input string what, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0t ns %s: %s is %h, expected %h", $time, phase, what, got, exp);
    end
  endtask

  // everything idle except fetch_enable_i and rst_ni
  task automatic clear_inputs();
    illegal_insn_i        <= 1'b0;
    ecall_insn_i          <= 1'b0;
    mret_insn_i           <= 1'b0;
    ebrk_insn_i           <= 1'b0;
    csr_status_i          <= 1'b0;
    pipe_flush_i          <= 1'b0;
    instr_valid_i         <= 1'b0;
    instr_i               <= '0;
    instr_compressed_i    <= '0;
    instr_is_compressed_i <= 1'b0;
    lsu_addr_last_i       <= '0;
    load_err_i            <= 1'b0;
    store_err_i           <= 1'b0;
    branch_set_i          <= 1'b0;
    jump_set_i            <= 1'b0;
    irq_i                 <= 1'b0;
    irq_req_ctrl_i        <= 1'b0;
    irq_id_ctrl_i         <= '0;
    m_ie_i                <= 1'b0;
    {stall_branch_i, stall_jump_i, stall_multdiv_i, stall_lsu_i} <= 4'h0;
  endtask

  // words the entry does not rely on get random fill
  task automatic drive_entry(input vec_t v);
    logic [XLEN-1:0]   fill_instr;
    logic [XLEN-1:0]   fill_addr;
    logic [COMP_W-1:0] fill_half;
    fill_instr = $random(seed);
    fill_addr  = $random(seed);
    fill_half  = $random(seed);
    instr_valid_i         <= 1'b1;
    illegal_insn_i        <= (v.kind == VK_ILLEGAL);
    ecall_insn_i          <= (v.kind == VK_ECALL);
    ebrk_insn_i           <= (v.kind == VK_EBREAK);
    mret_insn_i           <= (v.kind == VK_MRET);
    csr_status_i          <= (v.kind == VK_CSR);
    load_err_i            <= (v.kind == VK_LOAD);
    store_err_i           <= (v.kind == VK_STORE);
    instr_is_compressed_i <= v.compressed;
    instr_i               <= v.compressed ? fill_instr : v.instr;
    instr_compressed_i    <= v.compressed ? v.instr[COMP_W-1:0] : fill_half;
    lsu_addr_last_i       <= (v.kind == VK_LOAD || v.kind == VK_STORE) ? v.addr : fill_addr;
    irq_req_ctrl_i        <= (v.kind == VK_IRQ || v.kind == VK_IRQ_MASKED);
    m_ie_i                <= (v.kind == VK_IRQ);
    irq_id_ctrl_i         <= v.irq_id;
    {stall_branch_i, stall_jump_i, stall_multdiv_i, stall_lsu_i} <= v.stall;
  endtask

  // decode cycle of an entry, a taken interrupt preempts decoding
  task automatic check_decode(input vec_t v);
    logic decoding;
    decoding = (v.kind != VK_IRQ);
    // stalls act in the same cycle
    check_word("id_ready_o", id_ready_o, v.stall == 4'h0);
    check_word("is_decoding_o", is_decoding_o, decoding);
    // illegal encodings block register writes while decoding
    check_word("deassert_we_o", deassert_we_o, !decoding || v.kind == VK_ILLEGAL);
  endtask

  // flush or irq-taken cycle, or plain decode for the quiet entries
  task automatic check_entry(input vec_t v);
    logic decoding;
    decoding = (v.kind == VK_NONE) || (v.kind == VK_IRQ_MASKED);
    check_word("pc_set_o", pc_set_o, v.exp_strb[7]);
    if (v.exp_strb[7]) begin
      check_word("pc_mux_o", pc_mux_o, v.exp_pc_mux);
    end
    if (v.exp_strb[7] && v.exp_pc_mux == PC_EXC) begin
      check_word("exc_pc_mux_o", exc_pc_mux_o, v.exp_strb[6] ? EXC_PC_IRQ : EXC_PC_EXC);
    end
    check_word("csr_save_if_o", csr_save_if_o, v.exp_strb[5]);
    check_word("csr_save_id_o", csr_save_id_o, v.exp_strb[4]);
    check_word("csr_save_cause_o", csr_save_cause_o, v.exp_strb[3]);
    check_word("csr_restore_mret_id_o", csr_restore_mret_id_o, v.exp_strb[2]);
    check_word("irq_ack_o", irq_ack_o, v.exp_strb[1]);
    check_word("exc_ack_o", exc_ack_o, v.exp_strb[1]);
    check_word("halt_if_o", halt_if_o, v.exp_strb[0]);
    check_word("exc_cause_o", exc_cause_o, v.exp_cause);
    check_word("csr_mtval_o", csr_mtval_o, v.exp_mtval);
    check_word("id_ready_o", id_ready_o, v.stall == 4'h0);
    check_word("id_valid_o", id_valid_o, v.stall == 4'h0 && !v.exp_strb[0]);
    check_word("instr_valid_clear_o", instr_valid_clear_o, v.stall == 4'h0 || v.exp_strb[0]);
    check_word("is_decoding_o", is_decoding_o, decoding);
    check_word("deassert_we_o", deassert_we_o, !decoding);
    if (v.kind == VK_IRQ) begin
      check_word("irq_id_o", irq_id_o, v.irq_id);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic woken;
    int   waited;
    rst_ni         <= 1'b0;
    fetch_enable_i <= 1'b0;
    clear_inputs();
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    // boot address held while fetch is off
    phase = "boot";
    @(negedge clk_i);
    check_word("pc_set_o", pc_set_o, 1'b1);
    check_word("pc_mux_o", pc_mux_o, PC_BOOT);
    check_word("instr_req_o", instr_req_o, 1'b0);
    check_word("halt_if_o", halt_if_o, 1'b0);
    check_word("csr_mtval_o", csr_mtval_o, '0);
    @(posedge clk_i);
    fetch_enable_i <= 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    check_word("pc_set_o", pc_set_o, 1'b1);
    check_word("pc_mux_o", pc_mux_o, PC_BOOT);
    check_word("instr_req_o", instr_req_o, 1'b1);
    // first fetch, then decode
    repeat (2) @(posedge clk_i);

    for (int i = 0; i < NUM_VECS; i++) begin
      phase = $sformatf("entry %0d", i);
      @(posedge clk_i);
      drive_entry(vectors[i]);
      @(negedge clk_i);
      check_decode(vectors[i]);
      @(posedge clk_i);
      @(negedge clk_i);
      check_entry(vectors[i]);
      @(posedge clk_i);
      clear_inputs();
    end

    // taken jump redirects in the decode cycle itself
    phase = "jump";
    @(posedge clk_i);
    instr_valid_i <= 1'b1;
    jump_set_i    <= 1'b1;
    @(negedge clk_i);
    check_word("pc_set_o", pc_set_o, 1'b1);
    check_word("pc_mux_o", pc_mux_o, PC_JUMP);
    @(posedge clk_i);
    clear_inputs();

    // wfi as pipe flush, then wake on irq_i
    phase = "sleep";
    @(posedge clk_i);
    instr_valid_i <= 1'b1;
    pipe_flush_i  <= 1'b1;
    @(posedge clk_i);
    @(posedge clk_i);
    clear_inputs();
    repeat (4) begin
      @(negedge clk_i);
      check_word("instr_req_o", instr_req_o, 1'b0);
      check_word("halt_if_o", halt_if_o, 1'b1);
    end
    @(posedge clk_i);
    irq_i <= 1'b1;
    woken  = 1'b0;
    waited = 0;
    while (!woken && waited < WAKE_LIMIT) begin
      @(negedge clk_i);
      woken  = instr_req_o;
      waited = waited + 1;
    end
    checks++;
    assert (woken) else begin
      errors++;
      $display("sleep: instr_req_o stayed low for %0d cycles after irq_i", WAKE_LIMIT);
    end
    @(posedge clk_i);
    irq_i <= 1'b0;
    repeat (2) @(posedge clk_i);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verification
src/ctrl_pkg.sv
src/trap_if.sv
src/trap_cause_sel.sv
src/ctrl_fsm.sv
src/ctrl_top.sv
verification/tb_ctrl_top.sv
